// ==== hw/cart_cfg.svh ====
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// PRG space is 64 KB, which is four 16 KB banks.
`define CART_PRG_ADDR_BITS 16

// CHR space is one 8 KB pattern table set.
`define CART_CHR_ADDR_BITS 13

// loader, NROM and UxROM.
`define CART_MAP_CNT 3

// stages for the host register toggle crossing into m2.
`define CART_SYNC_DEPTH 3

`endif

// ==== hw/cart_pkg.sv ====
package cart_pkg;

    // mapper numbers at or above the slot count select nothing.
    typedef logic [4:0] map_sel_t;

    typedef struct packed {
        logic [20:0] reserved;
        logic        mirror_vertical;
        logic [4:0]  prg_size_log2;
        map_sel_t    select;
    } cfg_fields_t;

    // the host writes a raw word; the mux reads it back as fields.
    typedef union packed {
        logic [31:0] raw;
        cfg_fields_t fields;
    } cfg_word_u;

endpackage

// ==== hw/cart_buses.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

interface map_bus (
    input logic m2,
    input logic async_reset
);
    logic enable;
    logic mirror_vertical;
    logic [15:0] cpu_addr;
    logic [7:0] cpu_data_in;
    logic cpu_rw;
    logic [13:0] ppu_addr;
    logic ppu_rd;
    logic ppu_wr;

    logic [`CART_PRG_ADDR_BITS-1:0] prg_addr;
    logic prg_oe;
    logic prg_we;
    logic [`CART_CHR_ADDR_BITS-1:0] chr_addr;
    logic chr_oe;
    logic chr_we;
    logic ciram_a10;
    logic ciram_ce;

    modport mapper (
        input  m2, async_reset, enable, mirror_vertical,
        input  cpu_addr, cpu_data_in, cpu_rw, ppu_addr, ppu_rd, ppu_wr,
        output prg_addr, prg_oe, prg_we, chr_addr, chr_oe, chr_we,
        output ciram_a10, ciram_ce
    );

    modport mux (
        output enable, mirror_vertical,
        output cpu_addr, cpu_data_in, cpu_rw, ppu_addr, ppu_rd, ppu_wr,
        input  prg_addr, prg_oe, prg_we, chr_addr, chr_oe, chr_we,
        input  ciram_a10, ciram_ce
    );
endinterface

interface mem_bus;
    logic [`CART_PRG_ADDR_BITS-1:0] prg_addr;
    logic prg_we;
    logic [7:0] prg_wdata;
    logic [7:0] prg_rdata;
    logic [`CART_CHR_ADDR_BITS-1:0] chr_addr;
    logic chr_we;
    logic [7:0] chr_wdata;
    logic [7:0] chr_rdata;

    modport mem (
        input  prg_addr, prg_we, prg_wdata, chr_addr, chr_we, chr_wdata,
        output prg_rdata, chr_rdata
    );

    modport ctrl (
        output prg_addr, prg_we, prg_wdata, chr_addr, chr_we, chr_wdata,
        input  prg_rdata, chr_rdata
    );
endinterface

// ==== hw/loader_mapper.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module loader_mapper (
    map_bus.mapper bus
);
    localparam int PRG_W = `CART_PRG_ADDR_BITS;
    localparam int CHR_W = `CART_CHR_ADDR_BITS;

    logic prg_hit;
    logic chr_hit;

    // the upper half of CPU space reaches PRG, the 6000 window reaches CHR.
    assign prg_hit = bus.enable && bus.cpu_addr[15];
    assign chr_hit = bus.enable && (bus.cpu_addr[15:13] == 3'b011);

    assign bus.prg_addr = PRG_W'(bus.cpu_addr[14:0]);
    assign bus.prg_oe   = prg_hit && bus.cpu_rw;
    assign bus.prg_we   = prg_hit && !bus.cpu_rw;

    assign bus.chr_addr = CHR_W'(bus.cpu_addr[12:0]);
    assign bus.chr_oe   = chr_hit && bus.cpu_rw;
    assign bus.chr_we   = chr_hit && !bus.cpu_rw;

    // nametables stay idle while the host is loading.
    assign bus.ciram_a10 = 1'b0;
    assign bus.ciram_ce  = 1'b1;

endmodule

// ==== hw/nrom_mapper.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module nrom_mapper (
    map_bus.mapper bus
);
    localparam int PRG_W = `CART_PRG_ADDR_BITS;
    localparam int CHR_W = `CART_CHR_ADDR_BITS;

    assign bus.prg_addr = PRG_W'(bus.cpu_addr[14:0]);
    assign bus.prg_oe   = bus.enable && bus.cpu_rw && bus.cpu_addr[15];
    assign bus.prg_we   = 1'b0;

    // CHR is ROM here, so PPU writes fall on the floor.
    assign bus.chr_addr = CHR_W'(bus.ppu_addr[12:0]);
    assign bus.chr_oe   = bus.enable && bus.ppu_rd && !bus.ppu_addr[13];
    assign bus.chr_we   = 1'b0;

    assign bus.ciram_ce  = !(bus.enable && bus.ppu_addr[13]);
    assign bus.ciram_a10 = bus.mirror_vertical ? bus.ppu_addr[10] : bus.ppu_addr[11];

endmodule

// ==== hw/uxrom_mapper.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module uxrom_mapper (
    map_bus.mapper bus
);
    localparam int PRG_W = `CART_PRG_ADDR_BITS;
    localparam int CHR_W = `CART_CHR_ADDR_BITS;

    logic [1:0] bank;
    logic [1:0] cur_bank;
    logic prg_hit;
    logic chr_hit;

    assign prg_hit = bus.enable && bus.cpu_addr[15];
    assign chr_hit = bus.enable && !bus.ppu_addr[13];

    // any write into ROM space lands in the bank register.
    always_ff @(posedge bus.m2 or posedge bus.async_reset) begin
        if (bus.async_reset) begin
            bank <= 2'd0;
        end else if (!bus.enable) begin
            bank <= 2'd0;
        end else if (prg_hit && !bus.cpu_rw) begin
            bank <= bus.cpu_data_in[1:0];
        end
    end

    // C000 and up is pinned to the last bank.
    assign cur_bank = bus.cpu_addr[14] ? 2'd3 : bank;

    assign bus.prg_addr = PRG_W'({cur_bank, bus.cpu_addr[13:0]});
    assign bus.prg_oe   = prg_hit && bus.cpu_rw;
    assign bus.prg_we   = 1'b0;

    assign bus.chr_addr = CHR_W'(bus.ppu_addr[12:0]);
    assign bus.chr_oe   = chr_hit && bus.ppu_rd;
    assign bus.chr_we   = chr_hit && bus.ppu_wr;

    assign bus.ciram_ce  = !(bus.enable && bus.ppu_addr[13]);
    assign bus.ciram_a10 = bus.mirror_vertical ? bus.ppu_addr[10] : bus.ppu_addr[11];

endmodule

// ==== hw/map_mux.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module map_mux (
    input  logic m2,
    input  logic async_reset,
    input  logic [15:0] cpu_addr,
    input  logic [7:0] cpu_data_in,
    input  logic cpu_rw,
    input  logic [13:0] ppu_addr,
    input  logic [7:0] ppu_data_in,
    input  logic ppu_rd,
    input  logic ppu_wr,
    input  logic [31:0] wr_reg,
    input  logic [3:0] wr_reg_addr,
    input  logic wr_reg_changed,
    output logic cpu_oe,
    output logic ppu_oe,
    output logic ciram_a10,
    output logic ciram_ce,
    output logic [7:0] cpu_data_out,
    output logic [7:0] ppu_data_out,
    mem_bus.ctrl mem
);
    localparam int PRG_W = `CART_PRG_ADDR_BITS;
    localparam int CHR_W = `CART_CHR_ADDR_BITS;
    localparam int MAP_CNT = `CART_MAP_CNT;
    localparam int SYNC_D = `CART_SYNC_DEPTH;
    localparam int LOADER_SLOT = 0;

    cart_pkg::cfg_word_u cfg_q;
    logic [SYNC_D-1:0] toggle_sync;
    logic reg_load;

    logic [PRG_W-1:0] slot_prg_addr [MAP_CNT];
    logic slot_prg_oe [MAP_CNT];
    logic slot_prg_we [MAP_CNT];
    logic [CHR_W-1:0] slot_chr_addr [MAP_CNT];
    logic slot_chr_oe [MAP_CNT];
    logic slot_chr_we [MAP_CNT];
    logic slot_ciram_a10 [MAP_CNT];
    logic slot_ciram_ce [MAP_CNT];

    logic [PRG_W-1:0] sel_prg_addr;
    logic sel_prg_oe;
    logic sel_prg_we;
    logic [CHR_W-1:0] sel_chr_addr;
    logic sel_chr_oe;
    logic sel_chr_we;
    logic [PRG_W-1:0] prg_mask;
    logic loader_active;
    logic cpu_chr_rd;

    map_bus map_if[MAP_CNT] (.m2(m2), .async_reset(async_reset));

    loader_mapper loader_u (.bus(map_if[0]));
    nrom_mapper   nrom_u   (.bus(map_if[1]));
    uxrom_mapper  uxrom_u  (.bus(map_if[2]));

    // the host flips wr_reg_changed once per write; an edge out of the
    // synchroniser loads the word if it is aimed at register 0.
    assign reg_load = toggle_sync[SYNC_D-1] != toggle_sync[SYNC_D-2];

    always_ff @(posedge m2 or posedge async_reset) begin
        if (async_reset) begin
            toggle_sync <= '0;
            cfg_q.raw   <= '0;
        end else begin
            toggle_sync <= {toggle_sync[SYNC_D-2:0], wr_reg_changed};
            if (reg_load && wr_reg_addr == 4'd0) begin
                cfg_q.raw <= wr_reg;
            end
        end
    end

    for (genvar i = 0; i < MAP_CNT; i++) begin : g_slot
        assign map_if[i].enable = cfg_q.fields.select == cart_pkg::map_sel_t'(i);
        assign map_if[i].mirror_vertical = cfg_q.fields.mirror_vertical;
        assign map_if[i].cpu_addr = cpu_addr;
        assign map_if[i].cpu_data_in = cpu_data_in;
        assign map_if[i].cpu_rw = cpu_rw;
        assign map_if[i].ppu_addr = ppu_addr;
        assign map_if[i].ppu_rd = ppu_rd;
        assign map_if[i].ppu_wr = ppu_wr;

        assign slot_prg_addr[i] = map_if[i].prg_addr;
        assign slot_prg_oe[i] = map_if[i].prg_oe;
        assign slot_prg_we[i] = map_if[i].prg_we;
        assign slot_chr_addr[i] = map_if[i].chr_addr;
        assign slot_chr_oe[i] = map_if[i].chr_oe;
        assign slot_chr_we[i] = map_if[i].chr_we;
        assign slot_ciram_a10[i] = map_if[i].ciram_a10;
        assign slot_ciram_ce[i] = map_if[i].ciram_ce;
    end

    // an empty slot number leaves everything idle.
    always_comb begin
        sel_prg_addr = '0;
        sel_prg_oe   = 1'b0;
        sel_prg_we   = 1'b0;
        sel_chr_addr = '0;
        sel_chr_oe   = 1'b0;
        sel_chr_we   = 1'b0;
        ciram_a10    = 1'b0;
        ciram_ce     = 1'b1;
        for (int i = 0; i < MAP_CNT; i++) begin
            if (cfg_q.fields.select == cart_pkg::map_sel_t'(i)) begin
                sel_prg_addr = slot_prg_addr[i];
                sel_prg_oe   = slot_prg_oe[i];
                sel_prg_we   = slot_prg_we[i];
                sel_chr_addr = slot_chr_addr[i];
                sel_chr_oe   = slot_chr_oe[i];
                sel_chr_we   = slot_chr_we[i];
                ciram_a10    = slot_ciram_a10[i];
                ciram_ce     = slot_ciram_ce[i];
            end
        end
    end

    // a size of zero means the whole PRG space is visible.
    assign prg_mask = (cfg_q.fields.prg_size_log2 == 5'd0) ? '1 :
        PRG_W'((32'd1 << cfg_q.fields.prg_size_log2) - 32'd1);

    // only the loader moves CHR bytes over the CPU bus.
    assign loader_active = cfg_q.fields.select == cart_pkg::map_sel_t'(LOADER_SLOT);
    assign cpu_chr_rd = loader_active && sel_chr_oe;

    assign mem.prg_addr  = sel_prg_addr & prg_mask;
    assign mem.prg_we    = sel_prg_we;
    assign mem.prg_wdata = cpu_data_in;
    assign mem.chr_addr  = sel_chr_addr;
    assign mem.chr_we    = sel_chr_we;
    assign mem.chr_wdata = loader_active ? cpu_data_in : ppu_data_in;

    assign cpu_oe = sel_prg_oe || cpu_chr_rd;
    assign ppu_oe = ppu_rd && sel_chr_oe;
    assign cpu_data_out = cpu_chr_rd ? mem.chr_rdata : mem.prg_rdata;
    assign ppu_data_out = mem.chr_rdata;

endmodule

// ==== hw/cart_mem.sv ====
`timescale 1ns/1ps
`include "cart_cfg.svh"

module cart_mem (
    input logic m2,
    mem_bus.mem mem
);
    localparam int PRG_DEPTH = 1 << `CART_PRG_ADDR_BITS;
    localparam int CHR_DEPTH = 1 << `CART_CHR_ADDR_BITS;

    logic [7:0] prg_arr [PRG_DEPTH];
    logic [7:0] chr_arr [CHR_DEPTH];

    // the console samples read data within the same m2 cycle.
    assign mem.prg_rdata = prg_arr[mem.prg_addr];
    assign mem.chr_rdata = chr_arr[mem.chr_addr];

    always_ff @(posedge m2) begin
        if (mem.prg_we) begin
            prg_arr[mem.prg_addr] <= mem.prg_wdata;
        end
    end

    always_ff @(posedge m2) begin
        if (mem.chr_we) begin
            chr_arr[mem.chr_addr] <= mem.chr_wdata;
        end
    end

endmodule

// ==== hw/cart_top.sv ====
`timescale 1ns/1ps

module cart_top (
    input  logic m2,
    input  logic async_reset,
    input  logic [15:0] cpu_addr,
    inout  wire  [7:0] cpu_data,
    input  logic cpu_rw,
    output logic cpu_oe,
    input  logic [13:0] ppu_addr,
    inout  wire  [7:0] ppu_data,
    input  logic ppu_rd,
    input  logic ppu_wr,
    output logic ppu_oe,
    output logic ciram_a10,
    output logic ciram_ce,
    input  logic [31:0] wr_reg,
    input  logic [3:0] wr_reg_addr,
    input  logic wr_reg_changed
);
    logic [7:0] cpu_data_out;
    logic [7:0] ppu_data_out;

    mem_bus mem_if ();

    map_mux map_mux_u (
        .m2(m2),
        .async_reset(async_reset),
        .cpu_addr(cpu_addr),
        .cpu_data_in(cpu_data),
        .cpu_rw(cpu_rw),
        .ppu_addr(ppu_addr),
        .ppu_data_in(ppu_data),
        .ppu_rd(ppu_rd),
        .ppu_wr(ppu_wr),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed),
        .cpu_oe(cpu_oe),
        .ppu_oe(ppu_oe),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce),
        .cpu_data_out(cpu_data_out),
        .ppu_data_out(ppu_data_out),
        .mem(mem_if.ctrl)
    );

    cart_mem cart_mem_u (
        .m2(m2),
        .mem(mem_if.mem)
    );

    // the cartridge drives the shared data lines only on a claimed read.
    assign cpu_data = cpu_oe ? cpu_data_out : 8'bz;
    assign ppu_data = ppu_oe ? ppu_data_out : 8'bz;

endmodule

// ==== tests/cart_tb.sv ====
`timescale 1ns/1ps

module cart_tb;
    localparam int HALF_NS = 50;
    localparam int DRIVE_NS = 5;
    localparam int SAMPLE_NS = 90;
    localparam int RESET_CYCLES = 16;
    localparam int SETTLE_EDGES = 4;
    localparam int SETTLE_LIMIT_NS = 1000;
    localparam int RELEASE_LIMIT_NS = 1000;
    localparam int RUN_LIMIT_NS = 200000;

    logic m2;
    logic async_reset;
    logic [15:0] cpu_addr;
    logic cpu_rw;
    logic [13:0] ppu_addr;
    logic ppu_rd;
    logic ppu_wr;
    logic [31:0] wr_reg;
    logic [3:0] wr_reg_addr;
    logic wr_reg_changed;
    logic cpu_oe;
    logic ppu_oe;
    logic ciram_a10;
    logic ciram_ce;
    wire [7:0] cpu_data;
    wire [7:0] ppu_data;
    logic [7:0] cpu_wdata;
    logic cpu_drive;
    logic [7:0] ppu_wdata;
    logic ppu_drive;
    int checks = 0;
    int value_errors = 0;
    int other_errors = 0;
    bit aborted = 0;

    // the console side owns the data lines except during a claimed read.
    assign cpu_data = cpu_drive ? cpu_wdata : 8'bz;
    assign ppu_data = ppu_drive ? ppu_wdata : 8'bz;

    cart_top dut0 (
        .m2(m2),
        .async_reset(async_reset),
        .cpu_addr(cpu_addr),
        .cpu_data(cpu_data),
        .cpu_rw(cpu_rw),
        .cpu_oe(cpu_oe),
        .ppu_addr(ppu_addr),
        .ppu_data(ppu_data),
        .ppu_rd(ppu_rd),
        .ppu_wr(ppu_wr),
        .ppu_oe(ppu_oe),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed)
    );

    always #HALF_NS m2 = !m2;

    task automatic report_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        value_errors++;
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic finish_run();
        $display("checks run: %0d, value errors: %0d, other errors: %0d",
            checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic drive_idle();
        cpu_addr = 16'h0000;
        cpu_rw = 1'b1;
        cpu_wdata = 8'h00;
        cpu_drive = 1'b0;
        ppu_addr = 14'h0000;
        ppu_rd = 1'b0;
        ppu_wr = 1'b0;
        ppu_wdata = 8'h00;
        ppu_drive = 1'b0;
    endtask

    // every operation takes one m2 cycle, driven just after the rising edge.
    task automatic next_cycle();
        @(posedge m2);
        #DRIVE_NS;
        drive_idle();
    endtask

    task automatic wait_reset_release();
        int waited_ns;
        waited_ns = 0;
        while (!(cpu_oe === 1'b0 && ppu_oe === 1'b0 && ciram_ce === 1'b1)
            && waited_ns < RELEASE_LIMIT_NS) begin
            #1;
            waited_ns++;
        end
        if (waited_ns >= RELEASE_LIMIT_NS) begin
            other_errors++;
            $display("the cartridge outputs did not go idle after reset was released");
            aborted = 1;
        end
    endtask

    task automatic configure(input string name, input logic [31:0] word, input logic [3:0] addr);
        cart_pkg::cfg_word_u cfg;
        int edges;
        int waited_ns;
        logic last_m2;
        next_cycle();
        cfg.raw = word;
        wr_reg = word;
        wr_reg_addr = addr;
        wr_reg_changed = !wr_reg_changed;
        $display("%s: register %0d, select %0d, prg_size_log2 %0d, mirror_vertical %0b",
            name, addr, cfg.fields.select, cfg.fields.prg_size_log2,
            cfg.fields.mirror_vertical);
        edges = 0;
        waited_ns = 0;
        last_m2 = m2;
        while (edges < SETTLE_EDGES && waited_ns < SETTLE_LIMIT_NS) begin
            #1;
            waited_ns++;
            if (m2 && !last_m2) begin
                edges++;
            end
            last_m2 = m2;
        end
        if (edges < SETTLE_EDGES) begin
            other_errors++;
            $display("%s: m2 stopped before the new configuration could settle", name);
            aborted = 1;
        end
    endtask

    task automatic cpu_write(input string name, input logic [15:0] addr, input logic [7:0] data,
        input bit check_oe);
        next_cycle();
        cpu_addr = addr;
        cpu_rw = 1'b0;
        cpu_wdata = data;
        cpu_drive = 1'b1;
        #SAMPLE_NS;
        if (check_oe) begin
            checks++;
            if (cpu_oe !== 1'b0) begin
                report_value(name, 8'h00, {7'd0, cpu_oe});
            end
        end
    endtask

    task automatic cpu_read(input string name, input logic [15:0] addr, input logic [7:0] exp);
        next_cycle();
        cpu_addr = addr;
        #SAMPLE_NS;
        checks++;
        if (cpu_data !== exp) begin
            report_value(name, exp, cpu_data);
        end
    endtask

    task automatic ppu_write(input logic [13:0] addr, input logic [7:0] data);
        next_cycle();
        ppu_addr = addr;
        ppu_wr = 1'b1;
        ppu_wdata = data;
        ppu_drive = 1'b1;
        #SAMPLE_NS;
    endtask

    task automatic ppu_read(input string name, input logic [13:0] addr, input logic [7:0] exp);
        next_cycle();
        ppu_addr = addr;
        ppu_rd = 1'b1;
        #SAMPLE_NS;
        checks++;
        if (ppu_data !== exp) begin
            report_value(name, exp, ppu_data);
        end
    endtask

    // expected value packs ciram_ce above ciram_a10.
    task automatic check_nametable(input string name, input logic [13:0] addr,
        input logic [7:0] exp);
        next_cycle();
        ppu_addr = addr;
        #SAMPLE_NS;
        checks++;
        if ({6'd0, ciram_ce, ciram_a10} !== exp) begin
            report_value(name, exp, {6'd0, ciram_ce, ciram_a10});
        end
    endtask

    task automatic check_quiet(input string name, input logic [15:0] caddr,
        input logic [13:0] paddr);
        next_cycle();
        cpu_addr = caddr;
        ppu_addr = paddr;
        ppu_rd = 1'b1;
        #SAMPLE_NS;
        checks++;
        if ({cpu_oe, ppu_oe} !== 2'b00) begin
            report_value(name, 8'h00, {6'd0, cpu_oe, ppu_oe});
        end
    endtask

    task automatic run_cases();
        string line;
        string op;
        string name;
        int fd;
        int code;
        int n;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tests/cart_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open tests/cart_cases.txt for reading");
        end else begin
            while (!aborted && !$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                n = 0;
                if (code > 0) begin
                    n = $sscanf(line, "%s %s %h %h", op, name, a, b);
                end
                if (n == 4 && op != "#") begin
                    case (op)
                        "C": configure(name, a, b[3:0]);
                        "W": cpu_write(name, a[15:0], b[7:0], 1'b0);
                        "N": cpu_write(name, a[15:0], b[7:0], 1'b1);
                        "R": cpu_read(name, a[15:0], b[7:0]);
                        "V": ppu_write(a[13:0], b[7:0]);
                        "P": ppu_read(name, a[13:0], b[7:0]);
                        "M": check_nametable(name, a[13:0], b[7:0]);
                        "Q": check_quiet(name, a[15:0], b[13:0]);
                        default: begin
                            other_errors++;
                            $display("case %s has an unknown operation %s", name, op);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        m2 = 1'b0;
        async_reset = 1'b1;
        wr_reg = 32'd0;
        wr_reg_addr = 4'd0;
        wr_reg_changed = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge m2);
        #DRIVE_NS;
        async_reset = 1'b0;
        wait_reset_release();
        if (!aborted) begin
            run_cases();
        end
        finish_run();
    end

    initial begin
        #RUN_LIMIT_NS;
        other_errors++;
        $display("the run went past its time limit and was stopped");
        finish_run();
    end

endmodule

// ==== tests/cart_cases.txt ====
# op name a b. C: word, register address. W/N: CPU address, data. R: CPU address, expected.
# V: PPU address, data. P: PPU address, expected. M: PPU address, {ciram_ce,ciram_a10}. Q: CPU, PPU address.
N rst_wr 8123 5a
R rst_rd 8123 5a
W ld_chr0 6000 11
W ld_chr1 6abc 22
W ld_chr2 7fff 33
R ld_chr_rd 6abc 22
W ld_prg0 8000 a0
W ld_prg1 c000 a1
W ld_prg2 8005 b5
W ld_prg3 c005 c5
C cfg_nrom 00000001 0
R nrom_rd0 8000 a0
R nrom_rd1 c005 c5
P nrom_chr0 0000 11
P nrom_chr1 1fff 33
V nrom_chr_wr 0abc ee
P nrom_chr_keep 0abc 22
M mir_h0 2400 0
M mir_h1 2800 1
M mir_low 0400 2
C cfg_nrom_v 00000401 0
M mir_v0 2400 1
M mir_v1 2800 0
C cfg_uxrom 000001e2 0
W bank0 8000 00
R bank0_rd 8000 a0
W bank1 8000 01
R bank1_rd 8000 a1
R fixed1 c000 a1
W bank2 8000 02
R bank2_rd 8000 a0
W bank3 8000 03
R bank3_rd 8000 a1
V chr_ram_wr 0abc 44
P chr_ram_rd 0abc 44
C cfg_mask 000001c1 0
R mask_rd c005 b5
C cfg_ignored 00000002 1
R ignored_rd c005 b5
C cfg_none 00000007 0
Q none_rd 8000 0000

// ==== project.f ====
+incdir+hw
hw/cart_pkg.sv
hw/cart_buses.sv
hw/loader_mapper.sv
hw/nrom_mapper.sv
hw/uxrom_mapper.sv
hw/map_mux.sv
hw/cart_mem.sv
hw/cart_top.sv
tests/cart_tb.sv

// ==== Bender.yml ====
package:
  name: cart_mapper

sources:
  - include_dirs:
      - hw
    files:
      - hw/cart_pkg.sv
      - hw/cart_buses.sv
      - hw/loader_mapper.sv
      - hw/nrom_mapper.sv
      - hw/uxrom_mapper.sv
      - hw/map_mux.sv
      - hw/cart_mem.sv
      - hw/cart_top.sv
  - target: test
    files:
      - tests/cart_tb.sv
